//--- common/soc_pkg.sv
`default_nettype none

package soc_pkg;

  ////////////////////
  // Address map.

  localparam int BRAM_WORDS     = 1024;
  localparam int BRAM_ADDR_BITS = $clog2(BRAM_WORDS);

  localparam logic [31:0] UART_BASE_ADDR  = 32'h1000_0000;
  localparam logic [31:0] UART_TOP_ADDR   = 32'h1000_0010;
  localparam logic [31:0] CLINT_BASE_ADDR = 32'h0200_0000;
  localparam logic [31:0] CLINT_TOP_ADDR  = 32'h0201_0000;

  ////////////////////
  // Dividers.

  localparam logic [31:0] RTC_DIVIDER  = 32'd4;
  localparam logic [15:0] CLKS_PER_BIT = 16'd8;

  // Last count of a full bit and of half a bit.
  localparam logic [15:0] BIT_LAST      = CLKS_PER_BIT - 16'd1;
  localparam logic [15:0] HALF_BIT_LAST = (CLKS_PER_BIT >> 1) - 16'd1;

  ////////////////////
  // Register offsets.

  localparam logic [3:0] UART_TX_OFFSET     = 4'h0;
  localparam logic [3:0] UART_RX_OFFSET     = 4'h4;
  localparam logic [3:0] UART_STATUS_OFFSET = 4'h8;

  localparam logic [15:0] CLINT_MSIP_OFFSET     = 16'h0000;
  localparam logic [15:0] CLINT_MTIMECMP_OFFSET = 16'h4000;
  localparam logic [15:0] CLINT_MTIME_OFFSET    = 16'hBFF8;

  // Serial line states, shared by transmitter and receiver.
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

`default_nettype wire

//--- common/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

  logic        valid;
  logic        instr;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic [31:0] rdata;
  logic        ready;

  // Request side.
  modport master (
    output valid, instr, addr, wdata, wstrb,
    input  rdata, ready
  );

  // Target side.
  modport slave (
    input  valid, instr, addr, wdata, wstrb,
    output rdata, ready
  );

endinterface

`default_nettype wire

//--- hw/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  mem_bus_if.slave  cpu,
  mem_bus_if.master ram,
  mem_bus_if.master uart_bus,
  mem_bus_if.master clint_bus
);

  logic uart_hit;
  logic clint_hit;

  assign uart_hit  = (cpu.addr >= soc_pkg::UART_BASE_ADDR) &&
                     (cpu.addr < soc_pkg::UART_TOP_ADDR);
  assign clint_hit = (cpu.addr >= soc_pkg::CLINT_BASE_ADDR) &&
                     (cpu.addr < soc_pkg::CLINT_TOP_ADDR);

  // Anything outside the peripheral windows lands in RAM.
  assign ram.valid       = cpu.valid && !uart_hit && !clint_hit;
  assign uart_bus.valid  = cpu.valid && uart_hit;
  assign clint_bus.valid = cpu.valid && clint_hit;

  assign ram.instr = cpu.instr;
  assign ram.addr  = cpu.addr;
  assign ram.wdata = cpu.wdata;
  assign ram.wstrb = cpu.wstrb;

  assign uart_bus.instr = cpu.instr;
  assign uart_bus.addr  = cpu.addr ^ soc_pkg::UART_BASE_ADDR;
  assign uart_bus.wdata = cpu.wdata;
  assign uart_bus.wstrb = cpu.wstrb;

  assign clint_bus.instr = cpu.instr;
  assign clint_bus.addr  = cpu.addr ^ soc_pkg::CLINT_BASE_ADDR;
  assign clint_bus.wdata = cpu.wdata;
  assign clint_bus.wstrb = cpu.wstrb;

  // Response from whichever target is ready.
  always_comb begin
    if (ram.ready) begin
      cpu.rdata = ram.rdata;
      cpu.ready = 1'b1;
    end else if (uart_bus.ready) begin
      cpu.rdata = uart_bus.rdata;
      cpu.ready = 1'b1;
    end else if (clint_bus.ready) begin
      cpu.rdata = clint_bus.rdata;
      cpu.ready = 1'b1;
    end else begin
      cpu.rdata = '0;
      cpu.ready = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/bram.sv
`timescale 1ns/1ps
`default_nettype none

module bram (
  input  logic     clk,
  input  logic     rst_n,
  mem_bus_if.slave bus
);

  logic [31:0] mem [soc_pkg::BRAM_WORDS];
  logic [soc_pkg::BRAM_ADDR_BITS-1:0] word_addr;
  logic        access;
  logic        ready_q;
  logic [31:0] rdata_q;

  // Upper address bits are ignored, so the RAM repeats across the map.
  assign word_addr = bus.addr[soc_pkg::BRAM_ADDR_BITS+1:2];
  assign access    = bus.valid && !ready_q;

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (access) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.wstrb[i]) begin
          mem[word_addr][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
      rdata_q <= mem[word_addr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

endmodule

`default_nettype wire

//--- clint/clint.sv
`timescale 1ns/1ps
`default_nettype none

module clint (
  input  logic        clk,
  input  logic        rst_n,
  mem_bus_if.slave    bus,
  output logic        msip,
  output logic        mtip,
  output logic [63:0] mtime
);

  logic [31:0] rtc_count;
  logic        rtc_tick;
  logic [63:0] mtimecmp;
  logic [15:0] reg_offset;
  logic        access;
  logic        write;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic [31:0] read_word;

  assign reg_offset = bus.addr[15:0];
  assign access     = bus.valid && !ready_q;
  assign write      = access && (bus.wstrb != 4'b0000);

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

  ////////////////////
  // Real-time tick.

  assign rtc_tick = (rtc_count == soc_pkg::RTC_DIVIDER - 32'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_count <= '0;
    end else if (rtc_tick) begin
      rtc_count <= '0;
    end else begin
      rtc_count <= rtc_count + 32'd1;
    end
  end

  ////////////////////
  // Registers.

  always_comb begin
    case (reg_offset)
      soc_pkg::CLINT_MSIP_OFFSET:             read_word = {31'b0, msip};
      soc_pkg::CLINT_MTIMECMP_OFFSET:         read_word = mtimecmp[31:0];
      soc_pkg::CLINT_MTIMECMP_OFFSET + 16'd4: read_word = mtimecmp[63:32];
      soc_pkg::CLINT_MTIME_OFFSET:            read_word = mtime[31:0];
      soc_pkg::CLINT_MTIME_OFFSET + 16'd4:    read_word = mtime[63:32];
      default:                                read_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= read_word;
    end
  end

  // A software write to mtime overrides the tick.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q  <= 1'b0;
      msip     <= 1'b0;
      mtip     <= 1'b0;
      mtime    <= '0;
      mtimecmp <= '1;
    end else begin
      ready_q <= access;
      mtip    <= (mtime >= mtimecmp);
      if (rtc_tick) begin
        mtime <= mtime + 64'd1;
      end
      if (write) begin
        case (reg_offset)
          soc_pkg::CLINT_MSIP_OFFSET:             msip <= bus.wdata[0];
          soc_pkg::CLINT_MTIMECMP_OFFSET:         mtimecmp[31:0] <= bus.wdata;
          soc_pkg::CLINT_MTIMECMP_OFFSET + 16'd4: mtimecmp[63:32] <= bus.wdata;
          soc_pkg::CLINT_MTIME_OFFSET:            mtime[31:0] <= bus.wdata;
          soc_pkg::CLINT_MTIME_OFFSET + 16'd4:    mtime[63:32] <= bus.wdata;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- uart/uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart (
  input  logic     clk,
  input  logic     rst_n,
  mem_bus_if.slave bus,
  input  logic     rx,
  output logic     tx
);

  soc_pkg::uart_state_e tx_state;
  logic [15:0] tx_cnt;
  logic [2:0]  tx_bit;
  logic [7:0]  tx_shift;
  logic        tx_busy;
  logic        tx_wait;
  logic        tx_load;

  soc_pkg::uart_state_e rx_state;
  logic [15:0] rx_cnt;
  logic [2:0]  rx_bit;
  logic [7:0]  rx_shift;
  logic [7:0]  rx_data;
  logic        rx_meta;
  logic        rx_sync;
  logic        rx_valid;
  logic        rx_read;

  logic [3:0]  reg_offset;
  logic        access;
  logic        write;
  logic        ready_q;
  logic [31:0] rdata_q;

  assign reg_offset = bus.addr[3:0];
  assign access     = bus.valid && !ready_q;
  assign write      = (bus.wstrb != 4'b0000);

  assign tx_busy = (tx_state != soc_pkg::UART_IDLE);
  // TX write while a frame is running stalls the master.
  assign tx_wait = write && (reg_offset == soc_pkg::UART_TX_OFFSET) && tx_busy;
  assign tx_load = access && write && (reg_offset == soc_pkg::UART_TX_OFFSET) && !tx_busy;
  assign rx_read = access && !write && (reg_offset == soc_pkg::UART_RX_OFFSET);

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access && !tx_wait;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (reg_offset)
        soc_pkg::UART_RX_OFFSET:     rdata_q <= {24'h0, rx_data};
        soc_pkg::UART_STATUS_OFFSET: rdata_q <= {30'h0, rx_valid, tx_busy};
        default:                     rdata_q <= '0;
      endcase
    end
  end

  ////////////////////
  // Transmitter.

  always_ff @(posedge clk) begin
    if (tx_load) begin
      tx_shift <= bus.wdata[7:0];
    end else if (tx_state == soc_pkg::UART_DATA && tx_cnt == soc_pkg::BIT_LAST) begin
      tx_shift <= tx_shift >> 1;
    end
  end

  // The line follows the state one cycle later.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= soc_pkg::UART_IDLE;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      tx       <= 1'b1;
    end else begin
      case (tx_state)
        soc_pkg::UART_START: begin
          tx <= 1'b0;
          if (tx_cnt == soc_pkg::BIT_LAST) begin
            tx_cnt   <= '0;
            tx_state <= soc_pkg::UART_DATA;
          end else begin
            tx_cnt <= tx_cnt + 16'd1;
          end
        end
        soc_pkg::UART_DATA: begin
          tx <= tx_shift[0];
          if (tx_cnt == soc_pkg::BIT_LAST) begin
            tx_cnt <= '0;
            tx_bit <= tx_bit + 3'd1;
            if (tx_bit == 3'd7) begin
              tx_state <= soc_pkg::UART_STOP;
            end
          end else begin
            tx_cnt <= tx_cnt + 16'd1;
          end
        end
        soc_pkg::UART_STOP: begin
          tx <= 1'b1;
          if (tx_cnt == soc_pkg::BIT_LAST) begin
            tx_cnt   <= '0;
            tx_state <= soc_pkg::UART_IDLE;
          end else begin
            tx_cnt <= tx_cnt + 16'd1;
          end
        end
        default: begin
          tx     <= 1'b1;
          tx_cnt <= '0;
          tx_bit <= '0;
          if (tx_load) begin
            tx_state <= soc_pkg::UART_START;
          end
        end
      endcase
    end
  end

  ////////////////////
  // Receiver.

  always_ff @(posedge clk) begin
    if (rx_state == soc_pkg::UART_DATA && rx_cnt == soc_pkg::BIT_LAST) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
    if (rx_state == soc_pkg::UART_STOP && rx_cnt == soc_pkg::BIT_LAST && rx_sync) begin
      rx_data <= rx_shift;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_state <= soc_pkg::UART_IDLE;
      rx_cnt   <= '0;
      rx_bit   <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      if (rx_read) begin
        rx_valid <= 1'b0;
      end
      case (rx_state)
        // Check the start bit again at its centre.
        soc_pkg::UART_START: begin
          if (rx_cnt == soc_pkg::HALF_BIT_LAST) begin
            rx_cnt <= '0;
            if (rx_sync) begin
              rx_state <= soc_pkg::UART_IDLE;
            end else begin
              rx_state <= soc_pkg::UART_DATA;
            end
          end else begin
            rx_cnt <= rx_cnt + 16'd1;
          end
        end
        soc_pkg::UART_DATA: begin
          if (rx_cnt == soc_pkg::BIT_LAST) begin
            rx_cnt <= '0;
            rx_bit <= rx_bit + 3'd1;
            if (rx_bit == 3'd7) begin
              rx_state <= soc_pkg::UART_STOP;
            end
          end else begin
            rx_cnt <= rx_cnt + 16'd1;
          end
        end
        soc_pkg::UART_STOP: begin
          if (rx_cnt == soc_pkg::BIT_LAST) begin
            rx_cnt   <= '0;
            rx_state <= soc_pkg::UART_IDLE;
            if (rx_sync) begin
              rx_valid <= 1'b1;
            end
          end else begin
            rx_cnt <= rx_cnt + 16'd1;
          end
        end
        default: begin
          rx_cnt <= '0;
          rx_bit <= '0;
          if (!rx_sync) begin
            rx_state <= soc_pkg::UART_START;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/soc_periph.sv
`timescale 1ns/1ps
`default_nettype none

module soc_periph (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        mem_valid,
  input  logic        mem_instr,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wstrb,
  output logic [31:0] mem_rdata,
  output logic        mem_ready,
  input  logic        rx,
  output logic        tx,
  output logic        msip,
  output logic        mtip,
  output logic [63:0] mtime
);

  mem_bus_if cpu_bus ();
  mem_bus_if ram_bus ();
  mem_bus_if uart_bus ();
  mem_bus_if clint_bus ();

  // Processor port.
  assign cpu_bus.valid = mem_valid;
  assign cpu_bus.instr = mem_instr;
  assign cpu_bus.addr  = mem_addr;
  assign cpu_bus.wdata = mem_wdata;
  assign cpu_bus.wstrb = mem_wstrb;
  assign mem_rdata     = cpu_bus.rdata;
  assign mem_ready     = cpu_bus.ready;

  bus_decoder u_decoder (
    .cpu       (cpu_bus),
    .ram       (ram_bus),
    .uart_bus  (uart_bus),
    .clint_bus (clint_bus)
  );

  bram u_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (ram_bus)
  );

  uart u_uart (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (uart_bus),
    .rx    (rx),
    .tx    (tx)
  );

  clint u_clint (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (clint_bus),
    .msip  (msip),
    .mtip  (mtip),
    .mtime (mtime)
  );

endmodule

`default_nettype wire

//--- tb/tb_soc_periph.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;

  localparam int MAX_CYCLES = 20000;
  localparam int HS_LIMIT   = 500;
  localparam int FRAME_WAIT = 400;

  logic        clk;
  logic        rst_n;
  logic        mem_valid;
  logic        mem_instr;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic        rx;
  logic        tx;
  logic        msip;
  logic        mtip;
  logic [63:0] mtime;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          cycles;
  logic [31:0] rng_state;

  soc_periph uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .rx        (rx),
    .tx        (tx),
    .msip      (msip),
    .mtip      (mtip),
    .mtime     (mtime)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without reaching the end", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////
  // Helpers.

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [31:0] uart_addr(input logic [3:0] offset);
    return soc_pkg::UART_BASE_ADDR | {28'h0, offset};
  endfunction

  function automatic logic [31:0] clint_addr(input logic [15:0] offset);
    return soc_pkg::CLINT_BASE_ADDR | {16'h0, offset};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("Fail at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d check(s) wrong", name, errors - start_errors);
    end
  endtask

  // One request, held until the target pulses mem_ready.
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int waited;
    @(negedge clk);
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    mem_valid = 1'b1;
    waited    = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!mem_ready && waited < HS_LIMIT);
    if (!mem_ready) begin
      errors++;
      $display("Error: no mem_ready within %0d cycles for address %h", HS_LIMIT, addr);
    end
    rdata     = mem_rdata;
    mem_valid = 1'b0;
    mem_wstrb = 4'h0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] unused;
    bus_access(addr, data, strb, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(addr, 32'h0, 4'h0, data);
  endtask

  // Samples tx at bit centres and returns at the stop bit sample.
  task automatic uart_capture(output logic [7:0] data);
    int waited;
    data    = 8'h00;
    waited  = 0;
    while (tx !== 1'b0 && waited < FRAME_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0) begin
      errors++;
      $display("Error: no start bit seen on tx");
    end else begin
      repeat (soc_pkg::CLKS_PER_BIT / 2) @(negedge clk);
      if (tx !== 1'b0) report_mismatch("tx start bit", 32'd0, 32'(tx));
      for (int i = 0; i < 8; i++) begin
        repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
        data[i] = tx;
      end
      repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
      if (tx !== 1'b1) report_mismatch("tx stop bit", 32'd1, 32'(tx));
    end
  endtask

  task automatic uart_send(input logic [7:0] data);
    @(negedge clk);
    rx = 1'b0;
    repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = data[i];
      repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
    end
    rx = 1'b1;
    repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
  endtask

  ////////////////////
  // Tests.

  task automatic reset_state_test();
    int start_errors;
    logic [31:0] first;
    logic [31:0] second;
    start_errors = errors;
    if (mem_ready !== 1'b0) report_mismatch("mem_ready", 32'd0, 32'(mem_ready));
    if (msip !== 1'b0) report_mismatch("msip", 32'd0, 32'(msip));
    if (mtip !== 1'b0) report_mismatch("mtip", 32'd0, 32'(mtip));
    if (tx !== 1'b1) report_mismatch("tx", 32'd1, 32'(tx));
    if (mtime !== 64'd0) report_mismatch("mtime", 32'd0, mtime[31:0]);
    bus_read(clint_addr(soc_pkg::CLINT_MTIME_OFFSET), first);
    repeat (12) @(negedge clk);
    bus_read(clint_addr(soc_pkg::CLINT_MTIME_OFFSET), second);
    if (second <= first) begin
      errors++;
      $display("Fail at %0d ns: mtime expected above %h, got %h", $time, first, second);
    end
    finish_test("reset state", start_errors);
  endtask

  task automatic ram_test();
    int          start_errors;
    int          idx [8];
    int          k;
    logic [31:0] model [int];
    logic [31:0] r;
    logic [31:0] data;
    logic [31:0] word;
    logic [31:0] rd;
    logic [3:0]  strb;
    start_errors = errors;
    for (int i = 0; i < 8; i++) begin
      r      = next_random();
      idx[i] = int'(r[15:0]) % soc_pkg::BRAM_WORDS;
      data   = next_random();
      bus_write(idx[i] * 4, data, 4'hF);
      model[idx[i]] = data;
    end
    for (int i = 0; i < 16; i++) begin
      r    = next_random();
      k    = idx[r[2:0]];
      strb = r[7:4];
      data = next_random();
      bus_write(k * 4, data, strb);
      word = model[k];
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
      end
      model[k] = word;
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(idx[i] * 4, rd);
      if (rd !== model[idx[i]]) report_mismatch("mem_rdata", model[idx[i]], rd);
    end
    // Above the RAM depth the same words show up again.
    bus_read((idx[0] + soc_pkg::BRAM_WORDS) * 4, rd);
    if (rd !== model[idx[0]]) report_mismatch("mem_rdata alias", model[idx[0]], rd);
    data = next_random();
    bus_write((idx[1] + soc_pkg::BRAM_WORDS) * 4, data, 4'hF);
    bus_read(idx[1] * 4, rd);
    if (rd !== data) report_mismatch("mem_rdata alias write", data, rd);
    finish_test("ram", start_errors);
  endtask

  task automatic uart_tx_test();
    int          start_errors;
    logic [31:0] r;
    logic [31:0] status;
    logic [7:0]  sent0;
    logic [7:0]  sent1;
    logic [7:0]  got0;
    logic [7:0]  got1;
    time         first_end;
    time         second_done;
    start_errors = errors;
    r     = next_random();
    sent0 = r[7:0];
    sent1 = r[23:16];
    fork
      begin
        uart_capture(got0);
        first_end = $time;
        uart_capture(got1);
      end
      begin
        bus_write(uart_addr(soc_pkg::UART_TX_OFFSET), {24'h0, sent0}, 4'b0001);
        bus_write(uart_addr(soc_pkg::UART_TX_OFFSET), {24'h0, sent1}, 4'b0001);
        second_done = $time;
        bus_read(uart_addr(soc_pkg::UART_STATUS_OFFSET), status);
      end
    join
    if (got0 !== sent0) report_mismatch("tx frame 1 data", 32'(sent0), 32'(got0));
    if (got1 !== sent1) report_mismatch("tx frame 2 data", 32'(sent1), 32'(got1));
    if (second_done <= first_end) begin
      errors++;
      $display("Error: second TX write finished before the first frame ended");
    end
    if (status[0] !== 1'b1) report_mismatch("uart status bit 0", 32'd1, 32'(status[0]));
    finish_test("uart transmit", start_errors);
  endtask

  task automatic uart_rx_test();
    int          start_errors;
    int          polls;
    logic [31:0] r;
    logic [31:0] status;
    logic [31:0] rd;
    logic [7:0]  sent;
    start_errors = errors;
    r    = next_random();
    sent = r[15:8];
    uart_send(sent);
    polls  = 0;
    status = 32'h0;
    while (status[1] !== 1'b1 && polls < 50) begin
      bus_read(uart_addr(soc_pkg::UART_STATUS_OFFSET), status);
      polls++;
    end
    if (status[1] !== 1'b1) begin
      errors++;
      $display("Error: UART receive flag never set after %0d status reads", polls);
    end
    bus_read(uart_addr(soc_pkg::UART_RX_OFFSET), rd);
    if (rd[7:0] !== sent) report_mismatch("uart rx data", 32'(sent), rd);
    bus_read(uart_addr(soc_pkg::UART_STATUS_OFFSET), status);
    if (status[1] !== 1'b0) report_mismatch("uart status bit 1", 32'd0, 32'(status[1]));
    finish_test("uart receive", start_errors);
  endtask

  task automatic clint_test();
    int          start_errors;
    int          waited;
    int          limit;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [63:0] target;
    start_errors = errors;
    bus_write(clint_addr(soc_pkg::CLINT_MSIP_OFFSET), 32'd1, 4'hF);
    if (msip !== 1'b1) report_mismatch("msip", 32'd1, 32'(msip));
    bus_write(clint_addr(soc_pkg::CLINT_MSIP_OFFSET), 32'd0, 4'hF);
    if (msip !== 1'b0) report_mismatch("msip", 32'd0, 32'(msip));
    bus_read(clint_addr(soc_pkg::CLINT_MTIME_OFFSET + 16'd4), hi);
    bus_read(clint_addr(soc_pkg::CLINT_MTIME_OFFSET), lo);
    target = {hi, lo} + 64'd20;
    // Low half first, so the compare value never dips below mtime.
    bus_write(clint_addr(soc_pkg::CLINT_MTIMECMP_OFFSET), target[31:0], 4'hF);
    bus_write(clint_addr(soc_pkg::CLINT_MTIMECMP_OFFSET + 16'd4), target[63:32], 4'hF);
    if (mtip !== 1'b0) report_mismatch("mtip", 32'd0, 32'(mtip));
    limit  = 20 * soc_pkg::RTC_DIVIDER + 8;
    waited = 0;
    while (mtip !== 1'b1 && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (mtip !== 1'b1) begin
      errors++;
      $display("Error: mtip did not rise within %0d cycles", limit);
    end else if (mtime < target) begin
      report_mismatch("mtime at mtip", target[31:0], mtime[31:0]);
    end
    bus_write(clint_addr(soc_pkg::CLINT_MTIMECMP_OFFSET), 32'hFFFF_FFFF, 4'hF);
    bus_write(clint_addr(soc_pkg::CLINT_MTIMECMP_OFFSET + 16'd4), 32'hFFFF_FFFF, 4'hF);
    repeat (2) @(negedge clk);
    if (mtip !== 1'b0) report_mismatch("mtip", 32'd0, 32'(mtip));
    finish_test("clint", start_errors);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    mem_valid    = 1'b0;
    mem_instr    = 1'b0;
    mem_addr     = 32'h0;
    mem_wdata    = 32'h0;
    mem_wstrb    = 4'h0;
    rx           = 1'b1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    rng_state    = 32'h1eec;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    reset_state_test();
    ram_test();
    uart_tx_test();
    uart_rx_test();
    clint_test();

    $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- riscv_soc_periph.f
common/soc_pkg.sv
common/mem_bus_if.sv
hw/bus_decoder.sv
hw/bram.sv
clint/clint.sv
uart/uart.sv
hw/soc_periph.sv
tb/tb_soc_periph.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_soc_periph
FILELIST  := riscv_soc_periph.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -Fxq "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
